/* logic/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  way_sel_t;  // one-hot, bit per way
    typedef logic [1:0]  age_t;      // 3 = most recently used

    // one-hot selects and the age rule assume four ways
    localparam int NUM_WAYS = 4;

    localparam addr_t RESET_PC = 32'hBFC00000;

    // one block refill per miss
    typedef enum logic [1:0] {
        IDLE,
        SETUP,  // tag, valid and age write
        ADDR,   // arvalid until arready
        DATA    // a word per beat until rlast
    } refill_state_e;

endpackage

/* logic/pc_gen.sv */
`timescale 1ns/10ps

module pc_gen #(
    parameter int ICACHE_BLOCK_WORDS = 4
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             advance,
    input  logic             flush,
    input  fetch_pkg::addr_t flush_target,
    output fetch_pkg::addr_t pc0,
    output fetch_pkg::addr_t pc1,
    output logic             pc1_valid
);
    import fetch_pkg::*;

    localparam int OFF_W = $clog2(ICACHE_BLOCK_WORDS) + 2;

    addr_t pc_q;

    assign pc0 = pc_q;
    assign pc1 = pc_q + 32'd4;

    // second word only while still inside the block
    assign pc1_valid = (pc_q[OFF_W-1:2] != {(OFF_W - 2){1'b1}});

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q <= RESET_PC;
        end else if (flush) begin
            pc_q <= flush_target;  // redirect beats advance
        end else if (advance) begin
            pc_q <= pc_q + (pc1_valid ? 32'd8 : 32'd4);
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!resetn) pc0[1:0] == 2'b00
    ) else $error("fetch pc not word aligned: %h", pc0);

endmodule

/* logic/icache_tag_array.sv */
`timescale 1ns/10ps

module icache_tag_array #(
    parameter int  ICACHE_SETS        = 256,
    parameter int  ICACHE_BLOCK_WORDS = 4,
    localparam int IDX_W = $clog2(ICACHE_SETS),
    localparam int OFF_W = $clog2(ICACHE_BLOCK_WORDS) + 2,
    localparam int TAG_W = 32 - IDX_W - OFF_W
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic                                      rd_en,
    input  fetch_pkg::addr_t                          rd_addr,
    output logic [fetch_pkg::NUM_WAYS-1:0][TAG_W-1:0] rd_tags,
    output fetch_pkg::way_sel_t                       rd_valid,
    output fetch_pkg::way_sel_t                       victim,
    input  logic                                      touch_en,
    input  fetch_pkg::way_sel_t                       touch_way,
    input  fetch_pkg::addr_t                          touch_addr,
    input  logic                                      fill_en,
    input  fetch_pkg::way_sel_t                       fill_way,
    input  fetch_pkg::addr_t                          fill_addr
);
    import fetch_pkg::*;

    way_sel_t                       valid_mem [ICACHE_SETS];
    logic [NUM_WAYS-1:0][TAG_W-1:0] tag_mem [ICACHE_SETS];
    age_t [NUM_WAYS-1:0]            age_mem [ICACHE_SETS];

    logic [IDX_W-1:0]    rd_idx;
    logic [IDX_W-1:0]    fill_idx;
    logic [IDX_W-1:0]    age_idx;
    age_t [NUM_WAYS-1:0] rd_age;
    age_t [NUM_WAYS-1:0] cur_age;
    way_sel_t            age_way;
    logic                age_en;

    assign rd_idx   = rd_addr[OFF_W +: IDX_W];
    assign fill_idx = fill_addr[OFF_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < ICACHE_SETS; s++) begin
                valid_mem[s] <= '0;
            end
            rd_valid <= '0;
        end else begin
            if (fill_en) begin
                valid_mem[fill_idx] <= valid_mem[fill_idx] | fill_way;
            end
            if (rd_en) begin
                rd_valid <= valid_mem[rd_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_en && fill_way[w]) begin
                tag_mem[fill_idx][w] <= fill_addr[31 -: TAG_W];
            end
        end
        if (rd_en) begin
            rd_tags <= tag_mem[rd_idx];
            rd_age  <= age_mem[rd_idx];
        end
    end

    // refill and hit never overlap, fill taken first anyway
    assign age_way = fill_en ? fill_way : touch_way;
    assign age_idx = fill_en ? fill_idx : touch_addr[OFF_W +: IDX_W];
    assign cur_age = age_mem[age_idx];

    always_comb begin
        age_en = fill_en || touch_en;
        for (int w = 0; w < NUM_WAYS; w++) begin
            // invalid way counts as oldest whatever its stored age
            if (age_way[w] && valid_mem[age_idx][w] && cur_age[w] == 2'd3) begin
                age_en = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (age_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (age_way[w]) begin
                    age_mem[age_idx][w] <= 2'd3;
                end else if (cur_age[w] != 2'd0) begin
                    age_mem[age_idx][w] <= cur_age[w] - 2'd1;
                end
            end
        end
    end

    // lowest invalid way, else lowest way of age 0
    always_comb begin
        victim = way_sel_t'(1);
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (rd_age[w] == 2'd0) begin
                victim = way_sel_t'(1 << w);
            end
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!rd_valid[w]) begin
                victim = way_sel_t'(1 << w);
            end
        end
    end

    a_fill_onehot: assert property (
        @(posedge clk) disable iff (!resetn) fill_en |-> $onehot(fill_way)
    ) else $error("refill way not one-hot: %b", fill_way);

endmodule

/* logic/icache_data_array.sv */
`timescale 1ns/10ps

module icache_data_array #(
    parameter int  ICACHE_SETS        = 256,
    parameter int  ICACHE_BLOCK_WORDS = 4,
    localparam int DEPTH  = ICACHE_SETS * ICACHE_BLOCK_WORDS,
    localparam int WIDX_W = $clog2(DEPTH)
) (
    input  logic                                       clk,
    input  logic                                       rd_en,
    input  fetch_pkg::addr_t                           rd_addr0,
    input  fetch_pkg::addr_t                           rd_addr1,
    output fetch_pkg::inst_t [fetch_pkg::NUM_WAYS-1:0] rd_data0,
    output fetch_pkg::inst_t [fetch_pkg::NUM_WAYS-1:0] rd_data1,
    input  fetch_pkg::way_sel_t                        wr_way,
    input  fetch_pkg::addr_t                           wr_addr,
    input  fetch_pkg::inst_t                           wr_data
);
    import fetch_pkg::*;

    logic [WIDX_W-1:0] idx0;
    logic [WIDX_W-1:0] idx1;
    logic [WIDX_W-1:0] widx;

    // word index = set and offset bits
    assign idx0 = rd_addr0[2 +: WIDX_W];
    assign idx1 = rd_addr1[2 +: WIDX_W];
    assign widx = wr_addr[2 +: WIDX_W];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        inst_t mem [DEPTH];

        always_ff @(posedge clk) begin
            if (wr_way[w]) begin
                mem[widx] <= wr_data;
            end
            if (rd_en) begin
                rd_data0[w] <= mem[idx0];
                rd_data1[w] <= mem[idx1];  // old word on a same-edge write
            end
        end
    end

endmodule

/* logic/refill_ctrl.sv */
`timescale 1ns/10ps

module refill_ctrl #(
    parameter int  ICACHE_BLOCK_WORDS = 4,
    localparam int CNT_W = $clog2(ICACHE_BLOCK_WORDS),
    localparam int OFF_W = CNT_W + 2
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     miss,
    input  fetch_pkg::addr_t         miss_addr,
    input  fetch_pkg::way_sel_t      victim,
    output fetch_pkg::refill_state_e state,
    output fetch_pkg::addr_t         araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  fetch_pkg::inst_t         rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    output logic                     fill_en,
    output fetch_pkg::way_sel_t      fill_way,
    output fetch_pkg::addr_t         fill_addr,
    output fetch_pkg::way_sel_t      wr_way,
    output fetch_pkg::addr_t         wr_addr,
    output fetch_pkg::inst_t         wr_data
);
    import fetch_pkg::*;

    addr_t            blk_addr;  // block aligned
    way_sel_t         way_q;
    logic [CNT_W-1:0] word_cnt;
    logic             beat;

    assign beat = rvalid && rready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (miss) state <= SETUP;
                SETUP:   state <= ADDR;
                ADDR:    if (arready) state <= DATA;
                DATA:    if (beat && rlast) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && miss) begin
            blk_addr <= {miss_addr[31:OFF_W], {OFF_W{1'b0}}};
            way_q    <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            word_cnt <= '0;
        end else if (state == SETUP) begin
            word_cnt <= '0;
        end else if (beat) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // incrementing burst over the whole block
    assign arvalid = (state == ADDR);
    assign araddr  = blk_addr;
    assign rready  = (state == DATA);

    assign fill_en   = (state == SETUP);
    assign fill_way  = way_q;
    assign fill_addr = blk_addr;

    assign wr_way  = beat ? way_q : '0;
    assign wr_addr = {blk_addr[31:OFF_W], word_cnt, 2'b00};
    assign wr_data = rdata;

    // slave burst must end on the block's last word
    a_burst_len: assert property (
        @(posedge clk) disable iff (!resetn)
        beat |-> rlast == (word_cnt == CNT_W'(ICACHE_BLOCK_WORDS - 1))
    ) else $error("rlast not on the last word of the block");

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter int  ICACHE_SETS        = 256,
    parameter int  ICACHE_BLOCK_WORDS = 4,
    localparam int TAG_W = 32 - $clog2(ICACHE_SETS) - $clog2(ICACHE_BLOCK_WORDS) - 2
) (
    input  logic                                       clk,
    input  logic                                       resetn,
    input  logic                                       flush,
    input  logic                                       buffer_full,
    input  fetch_pkg::addr_t                           pc0,
    input  fetch_pkg::addr_t                           pc1,
    input  logic                                       pc1_valid,
    input  logic [fetch_pkg::NUM_WAYS-1:0][TAG_W-1:0]  rd_tags,
    input  fetch_pkg::way_sel_t                        rd_valid,
    input  fetch_pkg::inst_t [fetch_pkg::NUM_WAYS-1:0] rd_data0,
    input  fetch_pkg::inst_t [fetch_pkg::NUM_WAYS-1:0] rd_data1,
    input  fetch_pkg::refill_state_e                   refill_state,
    output logic                                       advance,
    output logic                                       miss,
    output fetch_pkg::addr_t                           hold_addr,
    output logic                                       touch_en,
    output fetch_pkg::way_sel_t                        touch_way,
    output fetch_pkg::inst_t                           fetch_inst0,
    output fetch_pkg::inst_t                           fetch_inst1,
    output fetch_pkg::addr_t                           fetch_pc0,
    output fetch_pkg::addr_t                           fetch_pc1,
    output logic                                       fetch_valid0,
    output logic                                       fetch_valid1,
    output logic                                       fetch_output_en
);
    import fetch_pkg::*;

    addr_t    pc0_q;
    addr_t    pc1_q;
    logic     valid0_q;
    logic     valid1_q;
    logic     refill_tail;  // last beat may not be in the read yet
    logic     refill_busy;
    way_sel_t hit_way;
    logic     hit;

    // pc1 shares the block, so one compare covers the pair
    always_comb begin
        fetch_inst0 = '0;
        fetch_inst1 = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = rd_valid[w] && (rd_tags[w] == pc0_q[31 -: TAG_W]);
            if (hit_way[w]) begin
                fetch_inst0 = rd_data0[w];
                fetch_inst1 = rd_data1[w];
            end
        end
    end

    assign hit         = |hit_way;
    assign refill_busy = (refill_state != IDLE) || refill_tail;

    assign fetch_output_en = valid0_q && hit && !refill_busy && !buffer_full;
    assign advance         = !valid0_q || fetch_output_en;
    assign miss            = valid0_q && !hit && (refill_state == IDLE);

    assign touch_en  = fetch_output_en;
    assign touch_way = hit_way;
    assign hold_addr = pc0_q;

    assign fetch_pc0    = pc0_q;
    assign fetch_pc1    = pc1_q;
    assign fetch_valid0 = valid0_q;
    assign fetch_valid1 = valid1_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid0_q    <= 1'b0;
            valid1_q    <= 1'b0;
            refill_tail <= 1'b0;
        end else begin
            refill_tail <= (refill_state != IDLE);
            if (flush) begin
                valid0_q <= 1'b0;  // squash held pair
                valid1_q <= 1'b0;
            end else if (advance) begin
                valid0_q <= 1'b1;
                valid1_q <= pc1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc0_q <= pc0;
            pc1_q <= pc1;
        end
    end

    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!resetn) valid0_q |-> $onehot0(hit_way)
    ) else $error("block present in more than one way: %b", hit_way);

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top #(
    parameter int ICACHE_SETS        = 256,
    parameter int ICACHE_BLOCK_WORDS = 4
) (
    input  logic             clk,
    input  logic             resetn,
    output fetch_pkg::addr_t araddr,
    output logic             arvalid,
    input  logic             arready,
    input  fetch_pkg::inst_t rdata,
    input  logic             rlast,
    input  logic             rvalid,
    output logic             rready,
    input  logic             flush,
    input  fetch_pkg::addr_t flush_target,
    input  logic             buffer_full,
    output fetch_pkg::inst_t fetch_inst0,
    output fetch_pkg::inst_t fetch_inst1,
    output fetch_pkg::addr_t fetch_pc0,
    output fetch_pkg::addr_t fetch_pc1,
    output logic             fetch_valid0,
    output logic             fetch_valid1,
    output logic             fetch_output_en
);
    import fetch_pkg::*;

    localparam int TAG_W = 32 - $clog2(ICACHE_SETS) - $clog2(ICACHE_BLOCK_WORDS) - 2;

    addr_t                          pc0;
    addr_t                          pc1;
    logic                           pc1_valid;
    logic                           advance;
    logic                           miss;
    addr_t                          hold_addr;
    addr_t                          rd_addr0;
    addr_t                          rd_addr1;
    logic [NUM_WAYS-1:0][TAG_W-1:0] rd_tags;
    way_sel_t                       rd_valid;
    way_sel_t                       victim;
    inst_t [NUM_WAYS-1:0]           rd_data0;
    inst_t [NUM_WAYS-1:0]           rd_data1;
    logic                           touch_en;
    way_sel_t                       touch_way;
    logic                           fill_en;
    way_sel_t                       fill_way;
    addr_t                          fill_addr;
    way_sel_t                       wr_way;
    addr_t                          wr_addr;
    inst_t                          wr_data;
    refill_state_e                  refill_state;

    // issue a new pair, or re-read the stalled one
    assign rd_addr0 = advance ? pc0 : hold_addr;
    assign rd_addr1 = advance ? pc1 : hold_addr + 32'd4;

    pc_gen #(
        .ICACHE_BLOCK_WORDS(ICACHE_BLOCK_WORDS)
    ) u_pc_gen (
        .clk, .resetn, .advance, .flush, .flush_target, .pc0, .pc1, .pc1_valid
    );

    // arrays read every cycle
    icache_tag_array #(
        .ICACHE_SETS(ICACHE_SETS),
        .ICACHE_BLOCK_WORDS(ICACHE_BLOCK_WORDS)
    ) u_tag_array (
        .clk, .resetn,
        .rd_en(1'b1),
        .rd_addr(rd_addr0),
        .rd_tags, .rd_valid, .victim,
        .touch_en, .touch_way,
        .touch_addr(hold_addr),
        .fill_en, .fill_way, .fill_addr
    );

    icache_data_array #(
        .ICACHE_SETS(ICACHE_SETS),
        .ICACHE_BLOCK_WORDS(ICACHE_BLOCK_WORDS)
    ) u_data_array (
        .clk,
        .rd_en(1'b1),
        .rd_addr0, .rd_addr1, .rd_data0, .rd_data1,
        .wr_way, .wr_addr, .wr_data
    );

    fetch_stage #(
        .ICACHE_SETS(ICACHE_SETS),
        .ICACHE_BLOCK_WORDS(ICACHE_BLOCK_WORDS)
    ) u_stage (
        .clk, .resetn, .flush, .buffer_full, .pc0, .pc1, .pc1_valid,
        .rd_tags, .rd_valid, .rd_data0, .rd_data1, .refill_state,
        .advance, .miss, .hold_addr, .touch_en, .touch_way,
        .fetch_inst0, .fetch_inst1, .fetch_pc0, .fetch_pc1,
        .fetch_valid0, .fetch_valid1, .fetch_output_en
    );

    refill_ctrl #(
        .ICACHE_BLOCK_WORDS(ICACHE_BLOCK_WORDS)
    ) u_refill (
        .clk, .resetn, .miss,
        .miss_addr(hold_addr),
        .victim,
        .state(refill_state),
        .araddr, .arvalid, .arready, .rdata, .rlast, .rvalid, .rready,
        .fill_en, .fill_way, .fill_addr, .wr_way, .wr_addr, .wr_data
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

/* bench/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);
    integer      seed;
    logic        busy;
    logic [31:0] base;
    integer      beat;

    // same memory pattern as the bench checker
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5A5A0000;
    endfunction

    initial begin
        seed    = 85;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        busy    = 1'b0;
        base    = '0;
        beat    = 0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy    <= 1'b0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                busy    <= 1'b1;
                base    <= araddr;  // burst is always incrementing, 4-byte words
                beat    <= 0;
                arready <= 1'b0;
            end else begin
                arready <= $random(seed) & 1;  // random ready gaps
            end
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            beat   <= beat + 1;
            if (rlast) begin
                busy  <= 1'b0;
                rlast <= 1'b0;
            end
        end else if (!rvalid && ($random(seed) % 3 != 0)) begin
            rvalid <= 1'b1;
            rdata  <= mem_word(base + beat * 4);
            rlast  <= (beat == BLOCK_WORDS - 1);
        end
    end

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb;
    localparam int          BLOCK_WORDS = 4;
    localparam int          SETS        = 256;
    localparam int          TIMEOUT     = 3000;
    localparam logic [31:0] BOOT_PC     = 32'hBFC00000;
    localparam logic [31:0] BLK_MASK    = ~(BLOCK_WORDS * 4 - 1);

    logic        clk;
    logic        resetn;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic        flush;
    logic [31:0] flush_target;
    logic        buffer_full;
    logic [31:0] fetch_inst0;
    logic [31:0] fetch_inst1;
    logic [31:0] fetch_pc0;
    logic [31:0] fetch_pc1;
    logic        fetch_valid0;
    logic        fetch_valid1;
    logic        fetch_output_en;

    integer        seed;
    integer        err_count;
    integer        test_err_start;
    integer        tests_run;
    integer        tests_failed;
    integer        pair_count;
    logic [31:0]   exp_pc;
    logic          exp_v1;
    logic [31:0]   ar_q[$];

    clock_gen u_clk (.clk, .resetn);

    fetch_top #(
        .ICACHE_SETS(SETS),
        .ICACHE_BLOCK_WORDS(BLOCK_WORDS)
    ) uut (
        .clk, .resetn, .araddr, .arvalid, .arready, .rdata, .rlast, .rvalid, .rready,
        .flush, .flush_target, .buffer_full,
        .fetch_inst0, .fetch_inst1, .fetch_pc0, .fetch_pc1,
        .fetch_valid0, .fetch_valid1, .fetch_output_en
    );

    axi_mem_model #(.BLOCK_WORDS(BLOCK_WORDS)) u_mem (
        .clk, .resetn, .araddr, .arvalid, .arready, .rdata, .rlast, .rvalid, .rready
    );

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5A5A0000;
    endfunction

    // second word only if pc0 is not the block's last word
    function automatic logic second_valid(input logic [31:0] pc);
        return ((pc >> 2) % BLOCK_WORDS) != BLOCK_WORDS - 1;
    endfunction

    function automatic logic ar_since(input int idx, input logic [31:0] addr);
        for (int i = idx; i < ar_q.size(); i++) begin
            if (ar_q[i] == addr) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        if (!cond) begin
            $display("%0t: %s", $time, what);
            err_count++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t: timeout while %s", $time, what);
        $display("test failed");
        $finish;
    endtask

    // pair checker
    always @(posedge clk) begin
        if (resetn) begin
            if (fetch_output_en) begin
                exp_v1 = second_valid(exp_pc);
                check_val("fetch_pc0", fetch_pc0, exp_pc);
                check_val("fetch_inst0", fetch_inst0, mem_word(exp_pc));
                check_val("fetch_valid1", {31'b0, fetch_valid1}, {31'b0, exp_v1});
                if (exp_v1) begin
                    check_val("fetch_pc1", fetch_pc1, exp_pc + 4);
                    check_val("fetch_inst1", fetch_inst1, mem_word(exp_pc + 4));
                end
                pair_count++;
                exp_pc = exp_pc + (exp_v1 ? 32'd8 : 32'd4);
            end
            if (flush) exp_pc = flush_target;  // flush cycle may still deliver
            if (arvalid && arready) ar_q.push_back(araddr);
        end
    end

    task automatic wait_pairs(input int n);
        int start;
        int cyc;
        start = pair_count;
        cyc = 0;
        while (pair_count - start < n && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (pair_count - start < n) abort_run("waiting for fetched pairs");
    endtask

    // quiet AXI for a few cycles means no refill in flight
    task automatic settle();
        int quiet;
        int cyc;
        quiet = 0;
        cyc = 0;
        while (quiet < 4 && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
            if (arvalid || rready) quiet = 0;
            else quiet++;
        end
        if (quiet < 4) abort_run("waiting for the refill to finish");
    endtask

    task automatic do_flush(input logic [31:0] target);
        @(posedge clk);
        flush        <= 1'b1;
        flush_target <= target;
        buffer_full  <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic hold_and_settle();
        @(posedge clk);
        buffer_full <= 1'b1;
        settle();
    endtask

    task automatic fetch_block(input logic [31:0] addr);
        do_flush(addr);
        wait_pairs(2);
        hold_and_settle();
    endtask

    task automatic start_test();
        test_err_start = err_count;
        tests_run++;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = err_count - test_err_start;
        if (errs != 0) tests_failed++;
        $display("[%0d] %s: %s (%0d errors)", num, name, errs == 0 ? "ok" : "FAILED", errs);
    endtask

    initial begin
        int          cyc;
        int          idx;
        int          distinct;
        bit          seen[logic [31:0]];
        logic [31:0] blk_a;
        logic [31:0] blk_f;
        logic [31:0] blk_g;

        flush        = 1'b0;
        flush_target = '0;
        buffer_full  = 1'b0;
        seed         = 85;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        pair_count   = 0;
        exp_pc       = BOOT_PC;

        start_test();
        cyc = 0;
        while (!resetn && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!resetn) abort_run("waiting for reset release");
        check_val("fetch_output_en", {31'b0, fetch_output_en}, 32'd0);
        check_val("fetch_valid0", {31'b0, fetch_valid0}, 32'd0);
        check_val("fetch_valid1", {31'b0, fetch_valid1}, 32'd0);
        check_val("arvalid", {31'b0, arvalid}, 32'd0);
        check_val("rready", {31'b0, rready}, 32'd0);
        wait_pairs(1);
        check_val("first araddr", ar_q[0], BOOT_PC & BLK_MASK);
        end_test(1, "reset and first pair");

        start_test();
        wait_pairs(40);
        end_test(2, "sequential stream");

        start_test();
        hold_and_settle();
        idx = ar_q.size();
        do_flush(BOOT_PC);
        wait_pairs(10);  // five blocks, all fetched before
        hold_and_settle();
        check_val("ar count after flush", ar_q.size() - idx, 0);
        distinct = 0;
        foreach (ar_q[i]) begin
            if (!seen.exists(ar_q[i])) distinct++;
            seen[ar_q[i]] = 1'b1;
        end
        check_val("ar count", ar_q.size(), distinct);
        end_test(3, "refetch after flush");

        // five blocks 4 KB apart share one set
        start_test();
        blk_a = 32'h0001_0800;
        for (int k = 0; k < 5; k++) begin
            idx = ar_q.size();
            fetch_block(blk_a + k * 32'h1000);
            expect_true(ar_since(idx, blk_a + k * 32'h1000), "no refill for a cold block");
        end
        idx = ar_q.size();
        fetch_block(blk_a);
        expect_true(ar_since(idx, blk_a), "evicted block A hit instead of refilling");
        // A took B's way, so D and E stay resident
        idx = ar_q.size();
        fetch_block(blk_a + 32'h3000);
        fetch_block(blk_a + 32'h4000);
        expect_true(!ar_since(idx, blk_a + 32'h3000), "block D refilled though resident");
        expect_true(!ar_since(idx, blk_a + 32'h4000), "block E refilled though resident");
        end_test(4, "set conflict replacement");

        start_test();
        do_flush(32'h0002_0000);
        idx = pair_count;
        cyc = 0;
        while (pair_count - idx < 30 && cyc < TIMEOUT) begin
            @(posedge clk);
            buffer_full <= $random(seed) & 1;
            @(negedge clk);
            cyc++;
        end
        if (pair_count - idx < 30) abort_run("streaming under back-pressure");
        hold_and_settle();
        end_test(5, "random back-pressure");

        start_test();
        blk_f = 32'h0003_0400;
        blk_g = 32'h0004_0600;
        do_flush(blk_f);
        cyc = 0;
        while (!rready && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (!rready) abort_run("waiting for a refill burst");
        do_flush(blk_g);
        wait_pairs(4);  // checker rejects any old-path pair
        hold_and_settle();
        idx = ar_q.size();
        fetch_block(blk_f);
        expect_true(!ar_since(idx, blk_f), "interrupted block missing after flush");
        end_test(6, "flush during refill");

        $display("tests: %0d run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/refill_ctrl.sv
logic/fetch_stage.sv
logic/fetch_top.sv
bench/clock_gen.sv
bench/axi_mem_model.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - files:
      - logic/fetch_pkg.sv
      - logic/pc_gen.sv
      - logic/icache_tag_array.sv
      - logic/icache_data_array.sv
      - logic/refill_ctrl.sv
      - logic/fetch_stage.sv
      - logic/fetch_top.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/axi_mem_model.sv
      - bench/fetch_tb.sv
